// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
TOP       ?= completion_tb
FILELIST  ?= list.f

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard logic/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf $(OBJ_DIR)

// File: list.f
+incdir+logic
logic/afu_pkg.sv
logic/completion_if.sv
logic/response_stats.sv
logic/compute_unit.sv
logic/done_control.sv
logic/host_mmio.sv
logic/completion_top.sv
sim/completion_tb.sv

// File: logic/afu_defs.svh
/*
	Width macros for the completion path
	Response data word, job result, statistics counter, job beat count
*/
`default_nettype none

`ifndef AFU_DEFS_SVH
`define AFU_DEFS_SVH

// One response data word
`define AFU_DATA_W 32
// Accumulated job result
`define AFU_RESULT_W 64
// Each statistics counter
`define AFU_COUNT_W 16
// Job length in OKAY beats
`define AFU_LEN_W 16

`endif

`default_nettype wire

// File: logic/afu_pkg.sv
/*
	Shared types of the completion path
	Done FSM state encoding
	Response kind carried with each beat
	Statistics record handed from the counters to the host
*/
`include "afu_defs.svh"

`default_nettype none

package afu_pkg;

	// Done FSM states
	// RESET_REQ drops reset_done for one cycle
	// RESET_PENDING waits for the soft reset to end
	typedef enum logic [2:0] {
		DONE_RESET,
		DONE_IDLE,
		DONE_RESET_REQ,
		DONE_RESET_PENDING,
		DONE_MMIO_REQ
	} done_state;

	// Kind of a response beat
	typedef enum logic [1:0] {
		RESP_OKAY  = 2'd0,
		RESP_RETRY = 2'd1,
		RESP_ERROR = 2'd2
	} resp_kind;

	// Per-kind beat counts, okay_count in the top bits
	typedef struct packed {
		logic [`AFU_COUNT_W-1:0] okay_count;
		logic [`AFU_COUNT_W-1:0] retry_count;
		logic [`AFU_COUNT_W-1:0] error_count;
	} response_stats_t;

endpackage

`default_nettype wire

// File: logic/completion_if.sv
/*
	Report channel from the done controller to the host register block
	Result word and statistics qualified by a valid level
	Acknowledge level returned by the host side
*/
`include "afu_defs.svh"

`default_nettype none

interface completion_if;

	// High while a loaded report is presented
	logic                      return_valid;
	// Latched job result
	logic [`AFU_RESULT_W-1:0]  return_word;
	// Latched beat counts
	afu_pkg::response_stats_t  stats;
	// High from the host read until return_valid falls
	logic                      return_ack;

	// Done controller side
	modport report (
		output return_valid,
		output return_word,
		output stats,
		input  return_ack
	);

	// Host register side
	modport host (
		input  return_valid,
		input  return_word,
		input  stats,
		output return_ack
	);

endinterface

`default_nettype wire

// File: logic/completion_top.sv
/*
	Completion path top level
	Compute unit, response statistics, done controller, host registers
	joined through one report channel
*/
`include "afu_defs.svh"

`default_nettype none

module completion_top (
	input  logic                     clock,
	input  logic                     rstn,
	input  logic                     soft_rstn,
	input  logic                     enable,
	input  logic                     job_start,
	input  logic [`AFU_LEN_W-1:0]    job_length,
	input  logic                     beat_valid,
	input  afu_pkg::resp_kind        beat_kind,
	input  logic [`AFU_DATA_W-1:0]   beat_data,
	input  logic                     mmio_read,
	output logic                     reset_done,
	output logic                     done_irq,
	output logic [`AFU_RESULT_W-1:0] read_result,
	output afu_pkg::response_stats_t read_stats
);

	logic                     cu_done;
	logic [`AFU_RESULT_W-1:0] cu_return;
	afu_pkg::response_stats_t stats;

	// Done controller to host registers
	completion_if report_bus ();

	response_stats i_response_stats (
		.clock      (clock),
		.rstn       (rstn),
		.soft_rstn  (soft_rstn),
		.beat_valid (beat_valid),
		.beat_kind  (beat_kind),
		.stats      (stats)
	);

	compute_unit i_compute_unit (
		.clock      (clock),
		.rstn       (rstn),
		.soft_rstn  (soft_rstn),
		.job_start  (job_start),
		.job_length (job_length),
		.beat_valid (beat_valid),
		.beat_kind  (beat_kind),
		.beat_data  (beat_data),
		.cu_done    (cu_done),
		.cu_return  (cu_return)
	);

	done_control i_done_control (
		.clock      (clock),
		.rstn       (rstn),
		.soft_rstn  (soft_rstn),
		.enable     (enable),
		.cu_done    (cu_done),
		.cu_return  (cu_return),
		.stats      (stats),
		.reset_done (reset_done),
		.report     (report_bus)
	);

	host_mmio i_host_mmio (
		.clock       (clock),
		.rstn        (rstn),
		.mmio_read   (mmio_read),
		.done_irq    (done_irq),
		.read_result (read_result),
		.read_stats  (read_stats),
		.report      (report_bus)
	);

endmodule

`default_nettype wire

// File: logic/compute_unit.sv
/*
	Compute unit
	Takes a job length, sums the data of OKAY beats
	Pulses cu_done one cycle after the last OKAY beat
*/
`include "afu_defs.svh"

`default_nettype none

module compute_unit (
	input  logic                     clock,
	input  logic                     rstn,
	input  logic                     soft_rstn,
	input  logic                     job_start,
	input  logic [`AFU_LEN_W-1:0]    job_length,
	input  logic                     beat_valid,
	input  afu_pkg::resp_kind        beat_kind,
	input  logic [`AFU_DATA_W-1:0]   beat_data,
	output logic                     cu_done,
	output logic [`AFU_RESULT_W-1:0] cu_return
);

	logic                  busy;
	logic [`AFU_LEN_W-1:0] target_len;
	logic [`AFU_LEN_W-1:0] beat_count;
	logic [`AFU_LEN_W-1:0] next_count;
	logic                  okay_beat;

	// Only OKAY beats of a running job count
	assign okay_beat  = busy && beat_valid && (beat_kind == afu_pkg::RESP_OKAY);
	assign next_count = beat_count + 1'b1;

	////////////////////////////////////////////////////////////
	// Job control
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			busy       <= 1'b0;
			target_len <= '0;
			beat_count <= '0;
			cu_done    <= 1'b0;
		end else if (!soft_rstn) begin
			busy       <= 1'b0;
			target_len <= '0;
			beat_count <= '0;
			cu_done    <= 1'b0;
		end else begin
			// Done is a single-cycle pulse
			cu_done <= 1'b0;
			if (job_start) begin
				target_len <= job_length;
				beat_count <= '0;
				// Zero-length job never runs
				busy       <= (job_length != '0);
			end else if (okay_beat) begin
				beat_count <= next_count;
				if (next_count == target_len) begin
					busy    <= 1'b0;
					cu_done <= 1'b1;
				end
			end
		end
	end

	// Running sum, held after the job for the done controller
	always_ff @(posedge clock) begin
		if (!soft_rstn || job_start) begin
			cu_return <= '0;
		end else if (okay_beat) begin
			cu_return <= cu_return + {{(`AFU_RESULT_W-`AFU_DATA_W){1'b0}}, beat_data};
		end
	end

	// Beats past the target never reach the count
	a_count_in_range: assert property (
		@(posedge clock) disable iff (!rstn)
		beat_count <= target_len
	) else $error("compute_unit beat count %0d above target %0d", beat_count, target_len);

endmodule

`default_nettype wire

// File: logic/done_control.sv
/*
	Done controller
	Reset synchronizer, soft reset edge detect and enable gate
	Done FSM that latches the job report, requests a soft reset
	and presents the report to the host register block
*/
`include "afu_defs.svh"

`default_nettype none

module done_control (
	input  logic                     clock,
	input  logic                     rstn,
	input  logic                     soft_rstn,
	input  logic                     enable,
	input  logic                     cu_done,
	input  logic [`AFU_RESULT_W-1:0] cu_return,
	input  afu_pkg::response_stats_t stats,
	output logic                     reset_done,
	completion_if.report             report
);

	logic                     sync_rstn;
	logic                     soft_meta;
	logic                     soft_sync;
	logic                     soft_rise;
	logic                     enabled;
	logic                     done_pending;
	logic                     done_flag;
	afu_pkg::done_state       current_state;
	afu_pkg::done_state       next_state;
	logic [`AFU_RESULT_W-1:0] result_latched;
	afu_pkg::response_stats_t stats_latched;

	// Reset release delayed one cycle
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			sync_rstn <= 1'b0;
		end else begin
			sync_rstn <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Soft reset edge detect and enable gate
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge sync_rstn) begin
		if (!sync_rstn) begin
			// Start high so a released soft reset is no edge
			soft_meta <= 1'b1;
			soft_sync <= 1'b1;
			soft_rise <= 1'b0;
			enabled   <= 1'b0;
		end else begin
			soft_meta <= soft_rstn;
			soft_sync <= soft_meta;
			soft_rise <= soft_meta && !soft_sync;
			enabled   <= enable;
		end
	end

	// Done pulse kept while the FSM is frozen in IDLE
	always_ff @(posedge clock or negedge sync_rstn) begin
		if (!sync_rstn) begin
			done_pending <= 1'b0;
		end else begin
			done_pending <= (current_state == afu_pkg::DONE_IDLE) && !enabled && done_flag;
		end
	end

	assign done_flag = cu_done || done_pending;

	////////////////////////////////////////////////////////////
	// Done FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge sync_rstn) begin
		if (!sync_rstn) begin
			current_state <= afu_pkg::DONE_RESET;
		end else if (enabled) begin
			current_state <= next_state;
		end
	end

	always_comb begin
		next_state = current_state;
		case (current_state)
			afu_pkg::DONE_RESET: next_state = afu_pkg::DONE_IDLE;
			afu_pkg::DONE_IDLE: begin
				if (done_flag) begin
					next_state = afu_pkg::DONE_RESET_REQ;
				end
			end
			afu_pkg::DONE_RESET_REQ: next_state = afu_pkg::DONE_RESET_PENDING;
			afu_pkg::DONE_RESET_PENDING: begin
				if (soft_rise) begin
					next_state = afu_pkg::DONE_MMIO_REQ;
				end
			end
			afu_pkg::DONE_MMIO_REQ: begin
				if (report.return_ack) begin
					next_state = afu_pkg::DONE_IDLE;
				end
			end
			default: next_state = afu_pkg::DONE_RESET;
		endcase
	end

	// Handshake levels, frozen with the state
	always_ff @(posedge clock or negedge sync_rstn) begin
		if (!sync_rstn) begin
			reset_done          <= 1'b1;
			report.return_valid <= 1'b0;
		end else if (enabled) begin
			case (current_state)
				afu_pkg::DONE_RESET_REQ: begin
					// One cycle low asks the host for a soft reset
					reset_done          <= 1'b0;
					report.return_valid <= 1'b0;
				end
				afu_pkg::DONE_MMIO_REQ: begin
					reset_done          <= 1'b1;
					report.return_valid <= !report.return_ack;
				end
				default: begin
					reset_done          <= 1'b1;
					report.return_valid <= 1'b0;
				end
			endcase
		end
	end

	// Report payload
	always_ff @(posedge clock) begin
		if (current_state == afu_pkg::DONE_IDLE) begin
			// Track results until a done is seen, even when frozen
			if (!done_pending) begin
				result_latched <= cu_return;
				stats_latched  <= stats;
			end
		end else if (enabled) begin
			case (current_state)
				afu_pkg::DONE_RESET: begin
					result_latched     <= '0;
					stats_latched      <= '0;
					report.return_word <= '0;
					report.stats       <= '0;
				end
				afu_pkg::DONE_MMIO_REQ: begin
					report.return_word <= result_latched;
					report.stats       <= stats_latched;
				end
				default: begin
					report.return_word <= report.return_word;
				end
			endcase
		end
	end

	// Host acknowledge only answers a presented report
	a_ack_in_mmio_req: assert property (
		@(posedge clock) disable iff (!sync_rstn)
		report.return_ack |-> (current_state == afu_pkg::DONE_MMIO_REQ)
	) else $error("return_ack high in state %s", current_state.name());

endmodule

`default_nettype wire

// File: logic/host_mmio.sv
/*
	Host register block
	Captures a presented report and raises done_irq
	A host read clears the interrupt and acknowledges the report
*/
`include "afu_defs.svh"

`default_nettype none

module host_mmio (
	input  logic                     clock,
	input  logic                     rstn,
	input  logic                     mmio_read,
	output logic                     done_irq,
	output logic [`AFU_RESULT_W-1:0] read_result,
	output afu_pkg::response_stats_t read_stats,
	completion_if.host               report
);

	logic valid_q;
	logic ack_pending;
	logic capture;

	// New report on the rising edge of return_valid
	assign capture = report.return_valid && !valid_q;

	// Ack drops together with return_valid
	assign report.return_ack = ack_pending && report.return_valid;

	////////////////////////////////////////////////////////////
	// Interrupt and acknowledge
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			valid_q     <= 1'b0;
			done_irq    <= 1'b0;
			ack_pending <= 1'b0;
		end else begin
			valid_q <= report.return_valid;
			if (capture) begin
				done_irq <= 1'b1;
			end else if (mmio_read && done_irq) begin
				done_irq    <= 1'b0;
				ack_pending <= 1'b1;
			end
			// Report withdrawn, acknowledge complete
			if (!report.return_valid) begin
				ack_pending <= 1'b0;
			end
		end
	end

	// Host-visible copy
	always_ff @(posedge clock) begin
		if (capture) begin
			read_result <= report.return_word;
			read_stats  <= report.stats;
		end
	end

	// Next report only after the previous one was read
	a_no_capture_over_irq: assert property (
		@(posedge clock) disable iff (!rstn)
		capture |-> !done_irq
	) else $error("host_mmio report captured over an unread interrupt");

endmodule

`default_nettype wire

// File: logic/response_stats.sv
/*
	Response beat statistics
	One saturating counter per beat kind
	Cleared by reset and held clear during a soft reset
*/
`include "afu_defs.svh"

`default_nettype none

module response_stats (
	input  logic                     clock,
	input  logic                     rstn,
	input  logic                     soft_rstn,
	input  logic                     beat_valid,
	input  afu_pkg::resp_kind        beat_kind,
	output afu_pkg::response_stats_t stats
);

	// Increment that sticks at all ones
	function automatic logic [`AFU_COUNT_W-1:0] sat_inc(
		input logic [`AFU_COUNT_W-1:0] value
	);
		if (&value) begin
			sat_inc = value;
		end else begin
			sat_inc = value + 1'b1;
		end
	endfunction

	////////////////////////////////////////////////////////////
	// Counters
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			stats <= '0;
		end else if (!soft_rstn) begin
			// Soft reset holds all counts at zero
			stats <= '0;
		end else if (beat_valid) begin
			case (beat_kind)
				afu_pkg::RESP_OKAY: begin
					stats.okay_count <= sat_inc(stats.okay_count);
				end
				afu_pkg::RESP_RETRY: begin
					stats.retry_count <= sat_inc(stats.retry_count);
				end
				afu_pkg::RESP_ERROR: begin
					stats.error_count <= sat_inc(stats.error_count);
				end
				// Unused encoding, not counted
				default: begin
					stats <= stats;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: sim/completion_tb.sv
/*
	Testbench for the completion path
	Random jobs of OKAY, RETRY and ERROR beats with a reference model
	Host sequence of soft reset, interrupt wait and register read
	Concurrent assertions on handshake timing and report values
*/
`include "afu_defs.svh"

`default_nettype none

module completion_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int JOBS           = 10;
	localparam int MAX_JOB_CYCLES = 60;
	localparam int CYCLE_LIMIT    = JOBS * MAX_JOB_CYCLES + 20;
	// Job whose end is seen with enable held low
	localparam int HOLD_JOB       = 4;
	localparam int HOLD_CYCLES    = 8;

	logic                     clock;
	logic                     rstn;
	logic                     soft_rstn;
	logic                     enable;
	logic                     job_start;
	logic [`AFU_LEN_W-1:0]    job_length;
	logic                     beat_valid;
	afu_pkg::resp_kind        beat_kind;
	logic [`AFU_DATA_W-1:0]   beat_data;
	logic                     mmio_read;
	logic                     reset_done;
	logic                     done_irq;
	logic [`AFU_RESULT_W-1:0] read_result;
	afu_pkg::response_stats_t read_stats;

	// Marker pulses, driven with the inputs they follow
	logic last_okay;
	logic soft_release;
	logic resume_mark;

	// Reference model of the current job
	logic [`AFU_RESULT_W-1:0] exp_sum;
	afu_pkg::response_stats_t exp_stats;
	afu_pkg::resp_kind        kind_q[$];
	logic [`AFU_DATA_W-1:0]   data_q[$];

	int          error_count;
	int          irq_count;
	int          cycle_count;
	logic        irq_q;

	completion_top i_dut (
		.clock       (clock),
		.rstn        (rstn),
		.soft_rstn   (soft_rstn),
		.enable      (enable),
		.job_start   (job_start),
		.job_length  (job_length),
		.beat_valid  (beat_valid),
		.beat_kind   (beat_kind),
		.beat_data   (beat_data),
		.mmio_read   (mmio_read),
		.reset_done  (reset_done),
		.done_irq    (done_irq),
		.read_result (read_result),
		.read_stats  (read_stats)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// Run limit sized from the longest possible job
	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, DUT handshake never completed", cycle_count);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// Rising edges of done_irq
	always @(negedge clock) begin
		if (!rstn) begin
			irq_q <= 1'b0;
		end else begin
			if (done_irq && !irq_q) begin
				irq_count = irq_count + 1;
			end
			irq_q <= done_irq;
		end
	end

	////////////////////////////////////////////////////////////
	// Job generation and reference model
	////////////////////////////////////////////////////////////

	task automatic build_job(input int len);
		int          i;
		int unsigned pick;
		kind_q.delete();
		data_q.delete();
		for (i = 0; i < len; i++) begin
			pick = $urandom % 4;
			// About half of the OKAY beats follow a RETRY or ERROR beat
			if (pick == 1) begin
				kind_q.push_back(afu_pkg::RESP_RETRY);
				data_q.push_back($urandom);
			end else if (pick == 2) begin
				kind_q.push_back(afu_pkg::RESP_ERROR);
				data_q.push_back($urandom);
			end
			// Job always ends on an OKAY beat
			kind_q.push_back(afu_pkg::RESP_OKAY);
			data_q.push_back($urandom);
		end
	endtask

	task automatic compute_expected();
		int i;
		exp_sum   = '0;
		exp_stats = '0;
		for (i = 0; i < kind_q.size(); i++) begin
			case (kind_q[i])
				afu_pkg::RESP_OKAY: begin
					exp_sum              = exp_sum + {32'b0, data_q[i]};
					exp_stats.okay_count = exp_stats.okay_count + 1'b1;
				end
				afu_pkg::RESP_RETRY: begin
					exp_stats.retry_count = exp_stats.retry_count + 1'b1;
				end
				default: begin
					exp_stats.error_count = exp_stats.error_count + 1'b1;
				end
			endcase
		end
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	task automatic drive_job(input int len, input bit hold_enable);
		int i;
		@(posedge clock);
		job_start  <= 1'b1;
		job_length <= len[`AFU_LEN_W-1:0];
		// Freeze the done FSM before the job ends
		if (hold_enable) begin
			enable <= 1'b0;
		end
		@(posedge clock);
		job_start <= 1'b0;
		for (i = 0; i < kind_q.size(); i++) begin
			beat_valid <= 1'b1;
			beat_kind  <= kind_q[i];
			beat_data  <= data_q[i];
			last_okay  <= (i == kind_q.size() - 1);
			@(posedge clock);
		end
		beat_valid <= 1'b0;
		last_okay  <= 1'b0;
	endtask

	task automatic release_enable();
		repeat (HOLD_CYCLES) @(posedge clock);
		enable      <= 1'b1;
		resume_mark <= 1'b1;
		@(posedge clock);
		resume_mark <= 1'b0;
	endtask

	// Soft reset on request, then read the report
	task automatic serve_host();
		do @(negedge clock); while (reset_done !== 1'b0);
		@(posedge clock);
		soft_rstn <= 1'b0;
		repeat (2) @(posedge clock);
		soft_rstn    <= 1'b1;
		soft_release <= 1'b1;
		@(posedge clock);
		soft_release <= 1'b0;
		do @(negedge clock); while (done_irq !== 1'b1);
		@(posedge clock);
		mmio_read <= 1'b1;
		@(posedge clock);
		mmio_read <= 1'b0;
		// Ack and return to IDLE
		repeat (2) @(posedge clock);
	endtask

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	// Reset request three cycles after the last OKAY beat
	a_reset_request: assert property (@(posedge clock) disable iff (!rstn)
		$past(last_okay && enable, 3) |-> !reset_done)
	else begin
		error_count = error_count + 1;
		$display("reset_done did not fall after the last OKAY beat of a job");
	end

	a_reset_done_back: assert property (@(posedge clock) disable iff (!rstn)
		$past(soft_release, 5) |-> reset_done)
	else begin
		error_count = error_count + 1;
		$display("reset_done still low five cycles after soft_rstn rose");
	end

	// Sync, edge detect, MMIO_REQ, valid, capture
	a_irq_after_soft: assert property (@(posedge clock) disable iff (!rstn)
		$past(soft_release, 5) |-> done_irq)
	else begin
		error_count = error_count + 1;
		$display("done_irq not raised five cycles after soft_rstn rose");
	end

	a_irq_result: assert property (@(posedge clock) disable iff (!rstn)
		$rose(done_irq) |-> (read_result == exp_sum))
	else begin
		error_count = error_count + 1;
		$display("[FAIL] irq_result expected %h actual %h", exp_sum, read_result);
	end

	a_irq_stats: assert property (@(posedge clock) disable iff (!rstn)
		$rose(done_irq) |-> (read_stats == exp_stats))
	else begin
		error_count = error_count + 1;
		$display("[FAIL] irq_stats expected %h actual %h", exp_stats, read_stats);
	end

	a_irq_held: assert property (@(posedge clock) disable iff (!rstn)
		$past(done_irq && !mmio_read) |-> done_irq)
	else begin
		error_count = error_count + 1;
		$display("done_irq dropped without a host read");
	end

	a_irq_cleared: assert property (@(posedge clock) disable iff (!rstn)
		$past(done_irq && mmio_read) |-> !done_irq)
	else begin
		error_count = error_count + 1;
		$display("done_irq still high the cycle after a host read");
	end

	// Outputs frozen once the low enable reaches the FSM
	a_enable_freeze: assert property (@(posedge clock) disable iff (!rstn)
		$past(!enable, 2) |-> ($stable(reset_done) && $stable(done_irq)))
	else begin
		error_count = error_count + 1;
		$display("reset_done or done_irq changed while enable was low");
	end

	// Pending done resumes three cycles after enable returns
	a_enable_resume: assert property (@(posedge clock) disable iff (!rstn)
		$past(resume_mark, 3) |-> !reset_done)
	else begin
		error_count = error_count + 1;
		$display("reset_done did not fall after enable was raised again");
	end

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin
		int j;
		int len;
		void'($urandom(32'hb7a7));
		error_count  = 0;
		irq_count    = 0;
		cycle_count  = 0;
		rstn         = 1'b0;
		soft_rstn    = 1'b1;
		enable       = 1'b1;
		job_start    = 1'b0;
		job_length   = '0;
		beat_valid   = 1'b0;
		beat_kind    = afu_pkg::RESP_OKAY;
		beat_data    = '0;
		mmio_read    = 1'b0;
		last_okay    = 1'b0;
		soft_release = 1'b0;
		resume_mark  = 1'b0;
		exp_sum      = '0;
		exp_stats    = '0;

		repeat (3) @(posedge clock);
		rstn <= 1'b1;
		// Reset sync and DONE_RESET exit
		repeat (5) @(posedge clock);

		for (j = 0; j < JOBS; j++) begin
			len = 1 + int'($urandom % 20);
			build_job(len);
			compute_expected();
			drive_job(len, j == HOLD_JOB);
			if (j == HOLD_JOB) begin
				release_enable();
			end
			serve_host();
			// Exactly one interrupt per job
			a_irq_count: assert (irq_count == j + 1)
			else begin
				error_count = error_count + 1;
				$display("[FAIL] interrupt_count expected %0d actual %0d", j + 1, irq_count);
			end
		end

		repeat (5) @(posedge clock);
		$display("Jobs %0d, interrupts %0d, errors %0d", JOBS, irq_count, error_count);
		if (error_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
